//--- rtl/wino_pkg.sv
package wino_pkg;

	// tile geometry of F(4,3)
	localparam int tile_in = 6;
	localparam int tile_out = 4;

	// arithmetic widths
	localparam int acc_w = 30;
	localparam int pix_w = 16;
	localparam int frac_lsb = 8;

	// pipeline depth of wino_adder_tree
	localparam int adder_lat = 3;

	// transform values wrap mod 2^30
	typedef logic signed [acc_w-1:0] acc_t;
	typedef logic [pix_w-1:0] pix_t;

	typedef logic [$clog2(tile_in)-1:0] row_idx_t;
	typedef logic [$clog2(tile_out)-1:0] beat_idx_t;

	typedef struct packed {
		acc_t [tile_in-1:0] x;
	} in_row_t;

	// one buffered column group, x[r] taken from input row r
	typedef struct packed {
		acc_t [tile_in-1:0] x;
	} mid_row_t;

	typedef struct packed {
		acc_t [tile_out-1:0] x;
	} acc_row_t;

	typedef struct packed {
		pix_t [tile_out-1:0] p;
	} out_row_t;

	typedef enum logic [1:0] {
		collect,
		drain,
		serialize
	} row_state_t;

	// scaled and negated terms for row r of A-transpose
	function automatic mid_row_t at_terms(mid_row_t v, int unsigned r);
		mid_row_t t;
		acc_t up3;
		acc_t up4;
		t = '0;
		up3 = v.x[3] <<< r;
		up4 = v.x[4] <<< r;
		t.x[1] = v.x[1];
		if (r == 0) begin
			t.x[0] = v.x[0];
			t.x[2] = v.x[2];
			t.x[3] = v.x[3];
			t.x[4] = v.x[4];
		end else begin
			// odd rows alternate sign on x2 and x4
			t.x[2] = (r % 2 == 1) ? -v.x[2] : v.x[2];
			t.x[3] = up3;
			t.x[4] = (r % 2 == 1) ? -up4 : up4;
			if (r == tile_out - 1) begin
				t.x[5] = v.x[5];
			end
		end
		return t;
	endfunction

endpackage

//--- rtl/wino_adder_tree.sv
`timescale 1ns/10ps

module wino_adder_tree (
	input  logic               clk,
	input  logic               i_rst,
	input  logic               i_valid,
	input  wino_pkg::mid_row_t i_terms,
	output logic               o_valid,
	output wino_pkg::acc_t     o_sum
);

	wino_pkg::acc_t pair_q [3];
	wino_pkg::acc_t part_q [2];
	logic [wino_pkg::adder_lat-1:0] valid_q;

	always_ff @(posedge clk) begin
		// stage one, neighbouring pairs
		pair_q[0] <= i_terms.x[0] + i_terms.x[1];
		pair_q[1] <= i_terms.x[2] + i_terms.x[3];
		pair_q[2] <= i_terms.x[4] + i_terms.x[5];
		// stage two
		part_q[0] <= pair_q[0] + pair_q[1];
		part_q[1] <= pair_q[2];
		// stage three, wraps to acc_w bits
		o_sum <= part_q[0] + part_q[1];
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[wino_pkg::adder_lat-2:0], i_valid};
		end
	end

	assign o_valid = valid_q[wino_pkg::adder_lat-1];

endmodule

//--- rtl/wino_row_transform.sv
`timescale 1ns/10ps

module wino_row_transform (
	input  logic               clk,
	input  logic               i_rst,
	input  logic               i_valid,
	input  wino_pkg::in_row_t  i_row,
	output logic               o_ready,
	output logic               o_mid_valid,
	output wino_pkg::mid_row_t o_mid
);

	wino_pkg::row_state_t state_q;
	wino_pkg::row_idx_t in_cnt_q;
	wino_pkg::row_idx_t ret_cnt_q;
	wino_pkg::beat_idx_t beat_cnt_q;

	wino_pkg::mid_row_t row_in;
	wino_pkg::acc_t tree_sum [wino_pkg::tile_out];
	logic [wino_pkg::tile_out-1:0] tree_valid;

	// 4x6 tile buffer, entry j holds row j of the transformed tile
	wino_pkg::mid_row_t col_buf [wino_pkg::tile_out];

	logic accept;
	logic ret_valid;
	logic last_in;
	logic last_ret;
	logic last_beat;

	assign o_ready = (state_q == wino_pkg::collect);
	assign accept = i_valid && o_ready;

	assign row_in = wino_pkg::mid_row_t'(i_row);

	// one tree per row of A-transpose
	for (genvar k = 0; k < wino_pkg::tile_out; k++) begin : g_tree
		wino_adder_tree u_tree (
			.clk     (clk),
			.i_rst   (i_rst),
			.i_valid (accept),
			.i_terms (wino_pkg::at_terms(row_in, k)),
			.o_valid (tree_valid[k]),
			.o_sum   (tree_sum[k])
		);
	end

	// all four trees see the same valid
	assign ret_valid = &tree_valid;

	assign last_in = (in_cnt_q == wino_pkg::row_idx_t'(wino_pkg::tile_in - 1));
	assign last_ret = (ret_cnt_q == wino_pkg::row_idx_t'(wino_pkg::tile_in - 1));
	assign last_beat = (beat_cnt_q == wino_pkg::beat_idx_t'(wino_pkg::tile_out - 1));

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state_q <= wino_pkg::collect;
			in_cnt_q <= '0;
			ret_cnt_q <= '0;
			beat_cnt_q <= '0;
			o_mid_valid <= 1'b0;
		end else begin
			o_mid_valid <= 1'b0;

			if (accept) begin
				in_cnt_q <= last_in ? '0 : in_cnt_q + 1'b1;
			end
			if (ret_valid) begin
				ret_cnt_q <= last_ret ? '0 : ret_cnt_q + 1'b1;
			end

			case (state_q)
				wino_pkg::collect: begin
					if (accept && last_in) begin
						state_q <= wino_pkg::drain;
					end
				end
				// wait for the sixth row to leave the trees
				wino_pkg::drain: begin
					if (ret_valid && last_ret) begin
						state_q <= wino_pkg::serialize;
					end
				end
				wino_pkg::serialize: begin
					o_mid_valid <= 1'b1;
					beat_cnt_q <= beat_cnt_q + 1'b1;
					if (last_beat) begin
						state_q <= wino_pkg::collect;
					end
				end
				default: begin
					state_q <= wino_pkg::collect;
				end
			endcase
		end
	end

	// results of input row r land in column r
	always_ff @(posedge clk) begin
		if (ret_valid) begin
			for (int j = 0; j < wino_pkg::tile_out; j++) begin
				col_buf[j].x[ret_cnt_q] <= tree_sum[j];
			end
		end
	end

	// transposed read, one buffer row per beat
	always_ff @(posedge clk) begin
		if (state_q == wino_pkg::serialize) begin
			o_mid <= col_buf[beat_cnt_q];
		end
	end

endmodule

//--- rtl/wino_col_transform.sv
`timescale 1ns/10ps

module wino_col_transform (
	input  logic               clk,
	input  logic               i_rst,
	input  logic               i_valid,
	input  wino_pkg::mid_row_t i_mid,
	output logic               o_valid,
	output wino_pkg::acc_row_t o_acc
);

	wino_pkg::acc_t tree_sum [wino_pkg::tile_out];
	logic [wino_pkg::tile_out-1:0] tree_valid;

	// same coefficients as the row side, applied across the six rows
	for (genvar k = 0; k < wino_pkg::tile_out; k++) begin : g_tree
		wino_adder_tree u_tree (
			.clk     (clk),
			.i_rst   (i_rst),
			.i_valid (i_valid),
			.i_terms (wino_pkg::at_terms(i_mid, k)),
			.o_valid (tree_valid[k]),
			.o_sum   (tree_sum[k])
		);
	end

	always_comb begin
		for (int k = 0; k < wino_pkg::tile_out; k++) begin
			o_acc.x[k] = tree_sum[k];
		end
	end

	// beats stream through, up to adder_lat in flight
	assign o_valid = &tree_valid;

endmodule

//--- rtl/wino_output_quant.sv
`timescale 1ns/10ps

module wino_output_quant (
	input  logic               clk,
	input  logic               i_rst,
	input  logic               i_valid,
	input  wino_pkg::acc_row_t i_acc,
	output logic               o_valid,
	output wino_pkg::out_row_t o_row
);

	wino_pkg::out_row_t quant;

	// relu then keep bits 23..8
	always_comb begin
		for (int k = 0; k < wino_pkg::tile_out; k++) begin
			if (i_acc.x[k][wino_pkg::acc_w-1]) begin
				quant.p[k] = '0;
			end else begin
				quant.p[k] = i_acc.x[k][wino_pkg::frac_lsb +: wino_pkg::pix_w];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			o_row <= quant;
		end
	end

endmodule

//--- rtl/wino_inverse_transform.sv
`timescale 1ns/10ps

module wino_inverse_transform (
	input  logic               clk,
	input  logic               i_rst,
	input  logic               i_valid,
	input  wino_pkg::in_row_t  i_row,
	output logic               o_ready,
	output logic               o_valid,
	output wino_pkg::out_row_t o_row
);

	logic mid_valid;
	wino_pkg::mid_row_t mid;
	logic acc_valid;
	wino_pkg::acc_row_t acc;

	// row pass and tile buffer
	wino_row_transform u_row (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_valid     (i_valid),
		.i_row       (i_row),
		.o_ready     (o_ready),
		.o_mid_valid (mid_valid),
		.o_mid       (mid)
	);

	// column pass
	wino_col_transform u_col (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_valid (mid_valid),
		.i_mid   (mid),
		.o_valid (acc_valid),
		.o_acc   (acc)
	);

	wino_output_quant u_quant (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_valid (acc_valid),
		.i_acc   (acc),
		.o_valid (o_valid),
		.o_row   (o_row)
	);

endmodule

//--- tests/tb_wino_inverse_transform.sv
`timescale 1ns/10ps

module tb_wino_inverse_transform;

	typedef wino_pkg::in_row_t [wino_pkg::tile_in-1:0] in_tile_t;
	typedef wino_pkg::out_row_t [wino_pkg::tile_out-1:0] out_tile_t;

	logic clk;
	logic i_rst;
	logic i_valid;
	wino_pkg::in_row_t i_row;
	logic o_ready;
	logic o_valid;
	wino_pkg::out_row_t o_row;

	wino_pkg::out_row_t exp_q [$];
	logic [15:0] lfsr_q = 16'd47;
	int value_errs = 0;
	int ready_errs = 0;
	int proto_errs = 0;
	int timeout_errs = 0;
	int burst = 0;
	int cycles = 0;
	// 37 tiles are sent, reset and the final drain fit in the extra 100
	int cycle_limit = 60 * 37 + 100;

	wino_inverse_transform uut (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_valid (i_valid),
		.i_row   (i_row),
		.o_ready (o_ready),
		.o_valid (o_valid),
		.o_row   (o_row)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	// rows of A-transpose for F(4,3)
	function automatic int coef_of(int k, int c);
		int row [6];
		case (k)
			0: row = '{1, 1, 1, 1, 1, 0};
			1: row = '{0, 1, -1, 2, -2, 0};
			2: row = '{0, 1, 1, 4, 4, 0};
			default: row = '{0, 1, -1, 8, -8, 1};
		endcase
		return row[c];
	endfunction

	function automatic wino_pkg::pix_t quant_of(wino_pkg::acc_t v);
		// negative values clamp to zero
		if (v[29]) begin
			return '0;
		end
		return v[23:8];
	endfunction

	// output row i is the column pass over column i of the row-transformed tile
	function automatic out_tile_t ref_transform(in_tile_t m);
		wino_pkg::acc_t t [6][4];
		wino_pkg::acc_t y;
		longint s;
		out_tile_t res;
		for (int r = 0; r < 6; r++) begin
			for (int j = 0; j < 4; j++) begin
				s = 0;
				for (int c = 0; c < 6; c++) begin
					y = m[r].x[c];
					s = s + longint'(coef_of(j, c)) * longint'(y);
				end
				t[r][j] = wino_pkg::acc_t'(s);
			end
		end
		for (int i = 0; i < 4; i++) begin
			for (int k = 0; k < 4; k++) begin
				s = 0;
				for (int r = 0; r < 6; r++) begin
					s = s + longint'(coef_of(k, r)) * longint'(t[r][i]);
				end
				res[i].p[k] = quant_of(wino_pkg::acc_t'(s));
			end
		end
		return res;
	endfunction

	// mode 0 is 20-bit signed, 1 is all negative, 2 is full 30-bit
	function automatic in_tile_t rand_tile(int mode);
		in_tile_t m;
		logic [31:0] v;
		for (int r = 0; r < 6; r++) begin
			for (int c = 0; c < 6; c++) begin
				v = take_bits(mode == 2 ? 30 : 20);
				case (mode)
					0: m[r].x[c] = {{10{v[19]}}, v[19:0]};
					// ~v is -v-1, so always negative
					1: m[r].x[c] = ~{10'd0, v[19:0]};
					default: m[r].x[c] = v[29:0];
				endcase
			end
		end
		return m;
	endfunction

	task automatic check_row(input wino_pkg::out_row_t exp, input wino_pkg::out_row_t act);
		if (act !== exp) begin
			$display("[FAIL] %0t: output row expected %h got %h", $time, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_ready(input logic exp, input logic act, input string what);
		if (act !== exp) begin
			$display("[FAIL] %0t: %s expected %b got %b", $time, what, exp, act);
			ready_errs++;
		end
	endtask

	// rows offered while o_ready is low carry junk and must be ignored
	task automatic send_tile(input in_tile_t m, input logic gaps);
		out_tile_t res;
		int r;
		r = 0;
		while (r < wino_pkg::tile_in) begin
			@(negedge clk);
			for (int c = 0; c < wino_pkg::tile_in; c++) begin
				i_row.x[c] = wino_pkg::acc_t'(take_bits(30));
			end
			i_valid = !(gaps && take_bits(2) == 32'd0);
			if (i_valid && o_ready) begin
				i_row = m[r];
				r++;
			end
		end
		res = ref_transform(m);
		for (int i = 0; i < wino_pkg::tile_out; i++) begin
			exp_q.push_back(res[i]);
		end
		@(negedge clk);
		i_valid = 1'b0;
		check_ready(1'b0, o_ready, "o_ready after the sixth row");
	endtask

	task automatic print_counts();
		$display("errors: %0d value, %0d handshake, %0d protocol, %0d timeout",
			value_errs, ready_errs, proto_errs, timeout_errs);
	endtask

	always @(negedge clk) begin
		if (!i_rst) begin
			if (o_valid) begin
				if (exp_q.size() == 0) begin
					$display("unexpected o_valid at %0t with no tile pending", $time);
					proto_errs++;
				end else begin
					check_row(exp_q.pop_front(), o_row);
				end
				burst = (burst == wino_pkg::tile_out - 1) ? 0 : burst + 1;
			end else if (burst != 0) begin
				$display("output rows of a tile were not on consecutive cycles at %0t", $time);
				proto_errs++;
				burst = 0;
			end
		end
	end

	initial begin
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		if (exp_q.size() != 0) begin
			$display("%0d expected output rows never arrived", exp_q.size());
		end
		timeout_errs++;
		print_counts();
		$display("Regression failed");
		$finish;
	end

	initial begin
		in_tile_t m;
		int ks [3];
		ks = '{1, 77, 32767};
		i_rst = 1'b1;
		i_valid = 1'b0;
		i_row = '0;
		repeat (10) @(negedge clk);
		i_rst = 1'b0;
		@(negedge clk);
		check_ready(1'b1, o_ready, "o_ready after reset");
		check_ready(1'b0, o_valid, "o_valid after reset");
		// impulse at (0,0), first output equals k
		for (int i = 0; i < 3; i++) begin
			m = '0;
			m[0].x[0] = wino_pkg::acc_t'(256 * ks[i]);
			send_tile(m, 1'b0);
		end
		repeat (16) send_tile(rand_tile(0), 1'b0);
		repeat (3) send_tile(rand_tile(1), 1'b0);
		repeat (3) send_tile(rand_tile(2), 1'b0);
		// back to back with idle gaps
		repeat (12) send_tile(rand_tile(0), 1'b1);
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (20) @(negedge clk);
		print_counts();
		if (value_errs + ready_errs + proto_errs + timeout_errs == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- compile.f
rtl/wino_pkg.sv
rtl/wino_adder_tree.sv
rtl/wino_row_transform.sv
rtl/wino_col_transform.sv
rtl/wino_output_quant.sv
rtl/wino_inverse_transform.sv
tests/tb_wino_inverse_transform.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal -f compile.f \
	--top-module tb_wino_inverse_transform -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
if [ $? -ne 0 ]; then
	cat "$log"
	echo "simulation exited with an error"
	exit 1
fi

cat "$log"
if grep -qx "Regression passed" "$log"; then
	exit 0
fi
exit 1
